//--- design/bus_port.sv
/*
 * Captures one outside access and replays it on a channel.
 * Outside ack and rdata come from registers; access is ignored for one cycle after ack.
 */
`timescale 1ns/100ps
`default_nettype none

module bus_port import mem_arb_pkg::*; (
    input  wire     clk,
    input  wire     reset,

    // Outside bus
    input  addr_t   addr,
    input  data_t   wdata,
    input  wire     wr_en,
    input  sel_t    sel,
    input  wire     access,
    output data_t   rdata,
    output logic    ack,

    // Channel towards the arbiter
    mem_bus_if.requester ch
);

    // Control
    logic  req_q;
    logic  ack_q;
    logic  take;
    logic  done;

    // Captured access
    addr_t addr_q;
    data_t wdata_q;
    logic  wr_en_q;
    sel_t  sel_q;
    data_t rdata_q;

    // Idle and not in the gap cycle after an ack
    assign take = access && !req_q && !ack_q;
    // Channel ack for our outstanding access
    assign done = req_q && ch.ack;

    // ========================================
    // Handshake state
    // ========================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            req_q <= 1'b0;
            ack_q <= 1'b0;
        end else begin
            // One-cycle pulse, one cycle behind the channel ack
            ack_q <= done;
            if (take) begin
                req_q <= 1'b1;
            end else if (done) begin
                req_q <= 1'b0;
            end
        end
    end

    // Fields held stable for the arbiter until ack
    always_ff @(posedge clk) begin
        if (take) begin
            addr_q  <= addr;
            wdata_q <= wdata;
            wr_en_q <= wr_en;
            sel_q   <= sel;
        end
        // Keep last read data across writes
        if (done && !wr_en_q) begin
            rdata_q <= ch.rdata;
        end
    end

    // Channel side
    assign ch.addr   = addr_q;
    assign ch.wdata  = wdata_q;
    assign ch.wr_en  = wr_en_q;
    assign ch.sel    = sel_q;
    assign ch.access = req_q;

    // Outside response
    assign ack   = ack_q;
    assign rdata = rdata_q;

endmodule

`default_nettype wire

//--- design/mem_arb_pkg.sv
/*
 * Shared widths and types for the CPU/MCGA memory subsystem.
 * Store depth must be a power of two; upper address bits alias onto it.
 */
`default_nettype none

package mem_arb_pkg;

    // ========================================
    // Bus widths
    // ========================================
    // Word address, bits 19 down to 1 of the byte address
    localparam int ADDR_W    = 19;
    localparam int DATA_W    = 16;
    // Bit 0 low byte, bit 1 high byte
    localparam int SEL_W     = 2;

    // ========================================
    // Memory model
    // ========================================
    localparam int MEM_DEPTH = 4096;
    localparam int IDX_W     = $clog2(MEM_DEPTH);
    // Cycles from acceptance to ack
    localparam int MEM_WAIT  = 3;
    localparam int WAIT_W    = $clog2(MEM_WAIT + 1);

    // Arbiter state encodings
    localparam int         ARB_ST_W          = 2;
    localparam logic [1:0] ST_IDLE           = 2'd0;
    localparam logic [1:0] ST_SERVING_CPU    = 2'd1;
    localparam logic [1:0] ST_SERVING_VID    = 2'd2;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [SEL_W-1:0]  sel_t;

    // One stored word
    // Whole-word view for reads and full writes, byte view for merges
    typedef union packed {
        data_t                 word;
        logic [SEL_W-1:0][7:0] bytes;
    } mem_word_u;

endpackage

`default_nettype wire

//--- design/mem_arb_top.sv
/*
 * Shared memory for a CPU bus and an MCGA video bus.
 * Each bus holds access with stable fields until its one-cycle ack.
 */
`timescale 1ns/100ps
`default_nettype none

module mem_arb_top import mem_arb_pkg::*; (
    input  wire   clk,
    input  wire   reset,

    // CPU bus
    input  addr_t cpu_addr,
    input  data_t cpu_wdata,
    input  wire   cpu_wr_en,
    input  sel_t  cpu_sel,
    input  wire   cpu_access,
    output data_t cpu_rdata,
    output logic  cpu_ack,

    // MCGA video bus
    input  addr_t vid_addr,
    input  data_t vid_wdata,
    input  wire   vid_wr_en,
    input  sel_t  vid_sel,
    input  wire   vid_access,
    output data_t vid_rdata,
    output logic  vid_ack
);

    // Port to arbiter, and arbiter to memory
    mem_bus_if cpu_ch ();
    mem_bus_if vid_ch ();
    mem_bus_if mem_ch ();

    // ========================================
    // Bus capture
    // ========================================
    bus_port i_cpu_port (
        .clk    (clk),
        .reset  (reset),
        .addr   (cpu_addr),
        .wdata  (cpu_wdata),
        .wr_en  (cpu_wr_en),
        .sel    (cpu_sel),
        .access (cpu_access),
        .rdata  (cpu_rdata),
        .ack    (cpu_ack),
        .ch     (cpu_ch)
    );

    bus_port i_vid_port (
        .clk    (clk),
        .reset  (reset),
        .addr   (vid_addr),
        .wdata  (vid_wdata),
        .wr_en  (vid_wr_en),
        .sel    (vid_sel),
        .access (vid_access),
        .rdata  (vid_rdata),
        .ack    (vid_ack),
        .ch     (vid_ch)
    );

    // Round robin onto the single memory channel
    mem_arbiter i_arbiter (
        .clk    (clk),
        .reset  (reset),
        .cpu_ch (cpu_ch),
        .vid_ch (vid_ch),
        .mem_ch (mem_ch)
    );

    mem_port i_mem (
        .clk    (clk),
        .reset  (reset),
        .ch     (mem_ch)
    );

endmodule

`default_nettype wire

//--- design/mem_arbiter.sv
/*
 * Round-robin arbiter for two channels onto one memory channel.
 * On a tie the port not served last wins; CPU wins the first tie after reset.
 */
`timescale 1ns/100ps
`default_nettype none

module mem_arbiter import mem_arb_pkg::*; (
    input  wire  clk,
    input  wire  reset,

    // Requesting channels
    mem_bus_if.responder cpu_ch,
    mem_bus_if.responder vid_ch,

    // Shared memory channel
    mem_bus_if.requester mem_ch
);

    logic [ARB_ST_W-1:0] arb_state;
    // High when video was served last
    logic                last_vid;
    logic                grant_cpu;
    logic                grant_vid;

    // ========================================
    // Grant state machine
    // ========================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            arb_state <= ST_IDLE;
            // CPU takes the first tie
            last_vid  <= 1'b1;
        end else begin
            case (arb_state)
                ST_IDLE: begin
                    if (cpu_ch.access && vid_ch.access) begin
                        // Tie, favour the port not served last
                        if (last_vid) begin
                            arb_state <= ST_SERVING_CPU;
                        end else begin
                            arb_state <= ST_SERVING_VID;
                        end
                    end else if (cpu_ch.access) begin
                        arb_state <= ST_SERVING_CPU;
                    end else if (vid_ch.access) begin
                        arb_state <= ST_SERVING_VID;
                    end
                end

                ST_SERVING_CPU: begin
                    if (mem_ch.ack) begin
                        last_vid  <= 1'b0;
                        arb_state <= ST_IDLE;
                    end
                end

                ST_SERVING_VID: begin
                    if (mem_ch.ack) begin
                        last_vid  <= 1'b1;
                        arb_state <= ST_IDLE;
                    end
                end

                default: begin
                    arb_state <= ST_IDLE;
                end
            endcase
        end
    end

    assign grant_cpu = (arb_state == ST_SERVING_CPU);
    assign grant_vid = (arb_state == ST_SERVING_VID);

    // ========================================
    // Channel routing
    // ========================================
    always_comb begin
        // Fields follow the granted port, CPU by default
        if (grant_vid) begin
            mem_ch.addr  = vid_ch.addr;
            mem_ch.wdata = vid_ch.wdata;
            mem_ch.wr_en = vid_ch.wr_en;
            mem_ch.sel   = vid_ch.sel;
        end else begin
            mem_ch.addr  = cpu_ch.addr;
            mem_ch.wdata = cpu_ch.wdata;
            mem_ch.wr_en = cpu_ch.wr_en;
            mem_ch.sel   = cpu_ch.sel;
        end

        // No access to memory while idle
        mem_ch.access = (grant_cpu && cpu_ch.access) || (grant_vid && vid_ch.access);

        // Response only to the granted port
        cpu_ch.ack   = grant_cpu && mem_ch.ack;
        vid_ch.ack   = grant_vid && mem_ch.ack;
        cpu_ch.rdata = grant_cpu ? mem_ch.rdata : '0;
        vid_ch.rdata = grant_vid ? mem_ch.rdata : '0;
    end

endmodule

`default_nettype wire

//--- design/mem_bus_if.sv
/*
 * One access channel: access held with stable fields until a one-cycle ack.
 */
`timescale 1ns/100ps
`default_nettype none

interface mem_bus_if import mem_arb_pkg::*; ();

    // Request fields, driven by the requester
    addr_t addr;
    data_t wdata;
    logic  wr_en;
    sel_t  sel;
    logic  access;

    // Response, driven by the responder
    data_t rdata;
    logic  ack;

    // Bus master side
    modport requester (
        output addr, wdata, wr_en, sel, access,
        input  rdata, ack
    );

    // Memory or slave side
    modport responder (
        input  addr, wdata, wr_en, sel, access,
        output rdata, ack
    );

endinterface

`default_nettype wire

//--- design/mem_port.sv
/*
 * Synchronous word store with MEM_WAIT cycles from acceptance to ack.
 * Only the low IDX_W address bits index the store; no refresh, no bursts.
 */
`timescale 1ns/100ps
`default_nettype none

module mem_port import mem_arb_pkg::*; (
    input  wire  clk,
    input  wire  reset,
    mem_bus_if.responder ch
);

    logic              busy_q;
    logic              ack_q;
    logic [WAIT_W-1:0] cnt_q;
    logic              accept;
    logic              fire;
    logic [IDX_W-1:0]  idx;
    data_t             rdata_q;
    mem_word_u         wr_word;
    mem_word_u         store [MEM_DEPTH];

    // Idle means no access in flight and not in the ack cycle
    assign accept = ch.access && !busy_q && !ack_q;
    // Last wait cycle, ack rises and the store is touched
    assign fire   = busy_q && (cnt_q == '0);
    // Upper address bits alias
    assign idx    = ch.addr[IDX_W-1:0];

    // ========================================
    // Wait-state counter
    // ========================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy_q <= 1'b0;
            ack_q  <= 1'b0;
            cnt_q  <= '0;
        end else begin
            ack_q <= fire;
            if (accept) begin
                busy_q <= 1'b1;
                cnt_q  <= WAIT_W'(MEM_WAIT - 1);
            end else if (fire) begin
                busy_q <= 1'b0;
            end else if (busy_q) begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    always_comb begin
        wr_word.word = ch.wdata;
    end

    // Word store, fields are still held by the requester here
    always_ff @(posedge clk) begin
        if (fire) begin
            if (ch.wr_en) begin
                if (&ch.sel) begin
                    store[idx].word <= wr_word.word;
                end else begin
                    // Unselected bytes keep their old value
                    for (int b = 0; b < SEL_W; b++) begin
                        if (ch.sel[b]) begin
                            store[idx].bytes[b] <= wr_word.bytes[b];
                        end
                    end
                end
            end else begin
                rdata_q <= store[idx].word;
            end
        end
    end

    assign ch.ack   = ack_q;
    assign ch.rdata = rdata_q;

endmodule

`default_nettype wire

//--- list.f
design/mem_arb_pkg.sv
design/mem_bus_if.sv
design/bus_port.sv
design/mem_arbiter.sv
design/mem_port.sv
design/mem_arb_top.sv
verif/tb_mem_arb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the shared memory testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    --top-module tb_mem_arb \
    -f list.f \
    -o sim_mem_arb

./obj_dir/sim_mem_arb > sim.log 2>&1
cat sim.log

# The log decides the result
if grep -qF '*** FAILED ***' sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation finished without failure"

//--- verif/tb_mem_arb.sv
/*
 * Testbench for mem_arb_top with directed and seeded random accesses on both buses.
 * Reads of unwritten words are never issued, since the store is not initialized.
 */
`timescale 1ns/100ps
`default_nettype none

module tb_mem_arb import mem_arb_pkg::*; ();

    typedef enum logic {PORT_CPU, PORT_VID} port_e;

    // One table row, a paired row goes out together with the next row
    typedef struct packed {
        logic  paired;
        port_e port;
        logic  wr;
        addr_t addr;
        data_t data;
        sel_t  sel;
        logic  has_exp;
        data_t exp;
    } entry_t;

    localparam int UNIT_LIMIT = 2 * (2 * MEM_WAIT + 8);
    localparam int N_RANDOM   = 20;

    logic  clk;
    logic  reset;
    addr_t cpu_addr;
    data_t cpu_wdata;
    logic  cpu_wr_en;
    sel_t  cpu_sel;
    logic  cpu_access;
    data_t cpu_rdata;
    logic  cpu_ack;
    addr_t vid_addr;
    data_t vid_wdata;
    logic  vid_wr_en;
    sel_t  vid_sel;
    logic  vid_access;
    data_t vid_rdata;
    logic  vid_ack;

    entry_t tbl [$];
    string  names [$];
    data_t  ref_mem [MEM_DEPTH];
    port_e  last_served;
    int     seed = 32'h346a;
    int     cycles;
    int     cycle_limit;
    int     data_errors;
    int     order_errors;
    int     other_errors;
    int     cpu_issued;
    int     vid_issued;
    int     cpu_acks;
    int     vid_acks;
    int     i;

    mem_arb_top i_dut (
        .clk        (clk),
        .reset      (reset),
        .cpu_addr   (cpu_addr),
        .cpu_wdata  (cpu_wdata),
        .cpu_wr_en  (cpu_wr_en),
        .cpu_sel    (cpu_sel),
        .cpu_access (cpu_access),
        .cpu_rdata  (cpu_rdata),
        .cpu_ack    (cpu_ack),
        .vid_addr   (vid_addr),
        .vid_wdata  (vid_wdata),
        .vid_wr_en  (vid_wr_en),
        .vid_sel    (vid_sel),
        .vid_access (vid_access),
        .vid_rdata  (vid_rdata),
        .vid_ack    (vid_ack)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Run limit from the table length
    initial begin
        cycles = 0;
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: the tests did not end within %0d cycles", cycle_limit);
        $display("*** FAILED ***");
        $finish;
    end

    // Every ack pulse seen on the outside buses
    always @(negedge clk) begin
        if (cpu_ack) cpu_acks++;
        if (vid_ack) vid_acks++;
    end

    // ========================================
    // Compare tasks
    // ========================================
    task automatic check_data(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
            data_errors++;
        end
    endtask

    task automatic check_order(input string name, input port_e exp, input port_e act);
        if (act !== exp) begin
            $display("[FAIL] %s first ack: expected %s, actual %s", name, exp.name(), act.name());
            order_errors++;
        end
    endtask

    // ========================================
    // Table building
    // ========================================
    task automatic add_write(input string name, input logic paired, input port_e port,
                             input addr_t addr, input data_t data, input sel_t sel);
        tbl.push_back('{paired, port, 1'b1, addr, data, sel, 1'b0, '0});
        names.push_back(name);
    endtask

    task automatic add_read(input string name, input logic paired, input port_e port,
                            input addr_t addr, input logic has_exp, input data_t exp);
        tbl.push_back('{paired, port, 1'b0, addr, '0, 2'b11, has_exp, exp});
        names.push_back(name);
    endtask

    // Pool of 16 words at index 0x200, random upper bits for aliasing
    task automatic add_random_op(input int u, input logic paired, input port_e port,
                                 input logic [15:0] known, inout logic [15:0] filled);
        logic [31:0] r;
        logic [3:0]  slot;
        logic        wr;
        sel_t        sel;
        addr_t       addr;
        string       name;
        r    = $random(seed);
        slot = r[3:0];
        // Unknown words get a full write first
        wr   = r[4] || !known[slot];
        sel  = known[slot] ? r[6:5] : 2'b11;
        if (sel == 2'b00) sel = 2'b11;
        addr = {r[13:7], 8'h20, slot};
        name = $sformatf("rand_%0d_%s", u, port.name());
        if (wr) begin
            add_write(name, paired, port, addr, r[31:16], sel);
            if (sel == 2'b11) filled[slot] = 1'b1;
        end else begin
            add_read(name, paired, port, addr, 1'b0, '0);
        end
    endtask

    task automatic add_random_units(input int units);
        logic [15:0] known;
        logic [15:0] filled;
        known = '0;
        for (int u = 0; u < units; u++) begin
            filled = known;
            if (($random(seed) & 1) != 0) begin
                add_random_op(u, 1'b1, PORT_CPU, known, filled);
                add_random_op(u, 1'b0, PORT_VID, known, filled);
            end else begin
                add_random_op(u, 1'b0, (($random(seed) & 1) != 0) ? PORT_VID : PORT_CPU,
                              known, filled);
            end
            // Words written in this unit are readable only from the next one
            known = filled;
        end
    endtask

    // ========================================
    // Reference model and driving
    // ========================================
    function automatic data_t merge_bytes(input data_t old_w, input data_t new_w, input sel_t sel);
        data_t res;
        res = old_w;
        if (sel[0]) res[7:0] = new_w[7:0];
        if (sel[1]) res[15:8] = new_w[15:8];
        return res;
    endfunction

    task automatic model_apply(input int k, output data_t exp);
        int a;
        // Upper address bits alias onto the store
        a   = int'(tbl[k].addr) % MEM_DEPTH;
        exp = '0;
        if (tbl[k].wr) ref_mem[a] = merge_bytes(ref_mem[a], tbl[k].data, tbl[k].sel);
        else if (tbl[k].has_exp) exp = tbl[k].exp;
        else exp = ref_mem[a];
        last_served = tbl[k].port;
    endtask

    function automatic logic port_ack(input int p);
        return (p == 0) ? cpu_ack : vid_ack;
    endfunction

    function automatic data_t port_rdata(input int p);
        return (p == 0) ? cpu_rdata : vid_rdata;
    endfunction

    task automatic drive_fields(input entry_t e);
        if (e.port == PORT_CPU) begin
            cpu_addr   = e.addr;
            cpu_wdata  = e.data;
            cpu_wr_en  = e.wr;
            cpu_sel    = e.sel;
            cpu_access = 1'b1;
            cpu_issued++;
        end else begin
            vid_addr   = e.addr;
            vid_wdata  = e.data;
            vid_wr_en  = e.wr;
            vid_sel    = e.sel;
            vid_access = 1'b1;
            vid_issued++;
        end
    endtask

    task automatic release_port(input int p);
        if (p == 0) cpu_access = 1'b0;
        else vid_access = 1'b0;
    endtask

    // One single access or one simultaneous pair
    task automatic apply_unit(input int first, input int count);
        int         waited;
        int         w;
        logic [1:0] pend;
        logic [1:0] hold;
        logic       any_ack;
        port_e      winner;
        port_e      got_first;
        int         idx [2];
        data_t      exp_d [2];
        // Tie goes to the port not served last
        if (count == 2) winner = (last_served == PORT_VID) ? PORT_CPU : PORT_VID;
        else winner = tbl[first].port;
        pend = 2'b00;
        hold = 2'b00;
        @(negedge clk);
        for (int k = first; k < first + count; k++) begin
            idx[int'(tbl[k].port)]  = k;
            pend[int'(tbl[k].port)] = 1'b1;
            drive_fields(tbl[k]);
        end
        // Model follows the predicted service order
        w = int'(winner);
        model_apply(idx[w], exp_d[w]);
        if (count == 2) model_apply(idx[1 - w], exp_d[1 - w]);
        waited  = 0;
        any_ack = 1'b0;
        while (pend != 2'b00 && waited < UNIT_LIMIT) begin
            @(negedge clk);
            waited++;
            // Access stays high through the ack cycle and drops one cycle later
            for (int p = 0; p < 2; p++) begin
                if (hold[p]) begin
                    release_port(p);
                    hold[p] = 1'b0;
                end
            end
            for (int p = 0; p < 2; p++) begin
                if (pend[p] && port_ack(p)) begin
                    if (!any_ack) got_first = (p == 0) ? PORT_CPU : PORT_VID;
                    any_ack = 1'b1;
                    if (!tbl[idx[p]].wr) check_data(names[idx[p]], exp_d[p], port_rdata(p));
                    hold[p] = 1'b1;
                    pend[p] = 1'b0;
                end
            end
        end
        if (hold != 2'b00) begin
            @(negedge clk);
            for (int p = 0; p < 2; p++) begin
                if (hold[p]) release_port(p);
            end
        end
        for (int p = 0; p < 2; p++) begin
            if (pend[p]) begin
                $display("No ack for test %s within %0d cycles", names[idx[p]], UNIT_LIMIT);
                other_errors++;
                release_port(p);
            end
        end
        if (count == 2 && any_ack) check_order(names[first], winner, got_first);
    endtask

    // ========================================
    // Test sequence
    // ========================================
    initial begin
        reset      = 1'b1;
        cpu_addr   = '0;
        cpu_wdata  = '0;
        cpu_wr_en  = 1'b0;
        cpu_sel    = '0;
        cpu_access = 1'b0;
        vid_addr   = '0;
        vid_wdata  = '0;
        vid_wr_en  = 1'b0;
        vid_sel    = '0;
        vid_access = 1'b0;
        // CPU wins the first tie after reset
        last_served = PORT_VID;

        // Tie right after reset
        add_write("tie_rst", 1'b1, PORT_CPU, 19'h00010, 16'hA5C3, 2'b11);
        add_write("tie_rst_vid", 1'b0, PORT_VID, 19'h00020, 16'h1234, 2'b11);
        // Read back and shared store
        add_read("cpu_rd", 1'b0, PORT_CPU, 19'h00010, 1'b1, 16'hA5C3);
        add_read("vid_rd", 1'b0, PORT_VID, 19'h00020, 1'b1, 16'h1234);
        add_read("cpu_rd_shared", 1'b0, PORT_CPU, 19'h00020, 1'b1, 16'h1234);
        // Byte lane merge
        add_write("byte_clear", 1'b0, PORT_VID, 19'h00030, 16'h0000, 2'b11);
        add_write("byte_lo", 1'b0, PORT_CPU, 19'h00030, 16'hBEEF, 2'b01);
        add_read("byte_lo_rd", 1'b0, PORT_VID, 19'h00030, 1'b1, 16'h00EF);
        add_write("byte_hi", 1'b0, PORT_CPU, 19'h00030, 16'h1277, 2'b10);
        add_read("byte_hi_rd", 1'b0, PORT_CPU, 19'h00030, 1'b1, 16'h12EF);
        // Addresses equal in the low 12 bits
        add_write("alias_wr", 1'b0, PORT_CPU, 19'h7F040, 16'h5A5A, 2'b11);
        add_read("alias_rd_hi", 1'b0, PORT_VID, 19'h01040, 1'b1, 16'h5A5A);
        add_read("alias_rd_lo", 1'b0, PORT_CPU, 19'h00040, 1'b1, 16'h5A5A);
        // Ties after CPU, then after video
        add_read("tie_a", 1'b1, PORT_CPU, 19'h00010, 1'b1, 16'hA5C3);
        add_read("tie_a_vid", 1'b0, PORT_VID, 19'h00020, 1'b1, 16'h1234);
        add_read("tie_b", 1'b1, PORT_CPU, 19'h00040, 1'b1, 16'h5A5A);
        add_read("tie_b_vid", 1'b0, PORT_VID, 19'h00030, 1'b1, 16'h12EF);
        add_read("tie_gap", 1'b0, PORT_VID, 19'h00010, 1'b1, 16'hA5C3);
        add_write("tie_c", 1'b1, PORT_CPU, 19'h00050, 16'hC0DE, 2'b11);
        add_read("tie_c_vid", 1'b0, PORT_VID, 19'h00050, 1'b1, 16'hC0DE);
        add_read("tie_d", 1'b1, PORT_CPU, 19'h00050, 1'b1, 16'hC0DE);
        add_write("tie_d_vid", 1'b0, PORT_VID, 19'h00050, 16'hF00D, 2'b11);
        add_read("tie_end", 1'b0, PORT_CPU, 19'h00050, 1'b1, 16'hF00D);
        add_random_units(N_RANDOM);

        // Reset cycles plus the per-row budget
        cycle_limit = tbl.size() * (2 * MEM_WAIT + 8) + 4;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        i = 0;
        while (i < tbl.size()) begin
            if (tbl[i].paired) begin
                apply_unit(i, 2);
                i += 2;
            end else begin
                apply_unit(i, 1);
                i += 1;
            end
        end

        // Quiet period catches stray acks
        repeat (4) @(negedge clk);
        if (cpu_acks != cpu_issued || vid_acks != vid_issued) begin
            $display("Ack count mismatch: CPU %0d acks for %0d accesses, video %0d for %0d",
                     cpu_acks, cpu_issued, vid_acks, vid_issued);
            other_errors++;
        end

        $display("Errors: data %0d, order %0d, other %0d", data_errors, order_errors,
                 other_errors);
        if (data_errors + order_errors + other_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
